/* fdiv_top.f */
hw/fp_fmt_pkg.sv
hw/fdiv_ctrl_pkg.sv
hw/fdiv_classify.sv
hw/fdiv_mant_divider.sv
hw/fdiv_round_pack.sv
hw/fdiv_top.sv
tb/tb_fdiv.sv

/* hw/fdiv_classify.sv */
/*
 * Operand unpacking, class detection and special-case result
 * selection for the divider
 */
`timescale 1ns/1ps
`default_nettype none

module fdiv_classify (
  input  fp_fmt_pkg::fp_word_t     a,
  input  fp_fmt_pkg::fp_word_t     b,
  output fp_fmt_pkg::fp_unpacked_t ua,
  output fp_fmt_pkg::fp_unpacked_t ub,
  output logic                     special_hit,
  output fp_fmt_pkg::fp_word_t     special_result,
  output fdiv_ctrl_pkg::fp_flags_t special_flags
);

  logic                 res_sign;
  fp_fmt_pkg::fp_word_t inf_word;
  fp_fmt_pkg::fp_word_t zero_word;

  // Subnormals are flushed, so any zero exponent counts as zero
  function automatic fp_fmt_pkg::fp_unpacked_t unpack_op(input fp_fmt_pkg::fp_word_t w);
    fp_fmt_pkg::fp_unpacked_t u;
    logic                     exp_ones;
    logic                     exp_zero;
    exp_ones  = (w.exp == {fp_fmt_pkg::exp_w{1'b1}});
    exp_zero  = (w.exp == '0);
    u.sign    = w.sign;
    u.exp     = w.exp;
    u.sig     = {~exp_zero, w.frac};
    u.is_nan  = exp_ones && (w.frac != '0);
    u.is_inf  = exp_ones && (w.frac == '0);
    u.is_zero = exp_zero;
    return u;
  endfunction

  assign ua = unpack_op(a);
  assign ub = unpack_op(b);

  assign res_sign  = ua.sign ^ ub.sign;
  assign inf_word  = {res_sign, {fp_fmt_pkg::exp_w{1'b1}}, {fp_fmt_pkg::man_w{1'b0}}};
  assign zero_word = {res_sign, {fp_fmt_pkg::exp_w{1'b0}}, {fp_fmt_pkg::man_w{1'b0}}};

  // Priority order matters, NaN first and divide by zero last
  always_comb begin
    special_hit    = 1'b1;
    special_result = zero_word;
    special_flags  = '0;
    if (ua.is_nan || ub.is_nan) begin
      special_result   = fp_fmt_pkg::canon_nan;
      special_flags.nv = 1'b1;
    end else if ((ua.is_inf && ub.is_inf) || (ua.is_zero && ub.is_zero)) begin
      special_result   = fp_fmt_pkg::canon_nan;
      special_flags.nv = 1'b1;
    end else if (ua.is_inf) begin
      special_result = inf_word;
    end else if (ub.is_inf) begin
      special_result = zero_word;
    end else if (ua.is_zero) begin
      special_result = zero_word;
    end else if (ub.is_zero) begin
      special_result   = inf_word;
      special_flags.dz = 1'b1;
    end else begin
      special_hit = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/fdiv_ctrl_pkg.sv */
/*
 * Divider control types: FSM states, rounding modes, exception
 * flags and the quotient bit count
 */
`default_nettype none

package fdiv_ctrl_pkg;

  // 24 significand bits, then guard, round and one sticky position
  localparam int div_iters = 27;

  typedef enum logic [2:0] {
    idle,
    unpack,
    divide,
    finish,
    done
  } fdiv_state_e;

  // Codes above rmm fall back to truncation
  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } round_mode_e;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

endpackage

`default_nettype wire

/* hw/fdiv_mant_divider.sv */
/*
 * Restoring radix-2 significand divider, one quotient bit per
 * cycle, with remainder and iteration counter
 */
`timescale 1ns/1ps
`default_nettype none

module fdiv_mant_divider (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                load,
  input  logic [fp_fmt_pkg::man_w:0]          dividend_sig,
  input  logic [fp_fmt_pkg::man_w:0]          divisor_sig,
  output logic [fdiv_ctrl_pkg::div_iters-1:0] quotient,
  output logic                                rem_nonzero,
  output logic                                q_valid
);

  typedef logic [$clog2(fdiv_ctrl_pkg::div_iters+1)-1:0] count_t;

  // Remainder is one bit wider than the operands to hold the shift
  logic [fp_fmt_pkg::man_w+1:0]        rem_q;
  logic [fp_fmt_pkg::man_w+1:0]        rem_diff;
  logic [fp_fmt_pkg::man_w+1:0]        rem_step;
  logic [fp_fmt_pkg::man_w:0]          div_q;
  logic [fdiv_ctrl_pkg::div_iters-1:0] quo_q;
  count_t                              count_q;
  logic                                stepping;
  logic                                q_bit;

  assign stepping = (count_q != '0);

  // ========================================
  // One restoring step
  // ========================================
  always_comb begin
    rem_diff = rem_q - {1'b0, div_q};
    q_bit    = (rem_q >= {1'b0, div_q});
    rem_step = q_bit ? rem_diff : rem_q;
  end

  // Iteration counter
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= count_t'(fdiv_ctrl_pkg::div_iters);
    end else if (stepping) begin
      count_q <= count_q - count_t'(1);
    end
  end

  // Working registers
  always_ff @(posedge clk) begin
    if (load) begin
      rem_q <= {1'b0, dividend_sig};
      div_q <= divisor_sig;
      quo_q <= '0;
    end else if (stepping) begin
      // Top bit of the step result is always clear here
      rem_q <= {rem_step[fp_fmt_pkg::man_w:0], 1'b0};
      quo_q <= {quo_q[fdiv_ctrl_pkg::div_iters-2:0], q_bit};
    end
  end

  // High in the cycle whose edge writes the last bit
  assign q_valid     = (count_q == count_t'(1));
  assign quotient    = quo_q;
  assign rem_nonzero = (rem_q != '0);

endmodule

`default_nettype wire

/* hw/fdiv_round_pack.sv */
/*
 * Quotient normalization, exponent range check, rounding in five
 * modes and packing of the final word and flags
 */
`timescale 1ns/1ps
`default_nettype none

module fdiv_round_pack (
  input  logic [fdiv_ctrl_pkg::div_iters-1:0] quotient,
  input  logic                                rem_nonzero,
  input  logic                                sign,
  input  logic signed [fp_fmt_pkg::exp_w+1:0] exp_diff,
  input  fdiv_ctrl_pkg::round_mode_e          mode,
  output fp_fmt_pkg::fp_word_t                packed_word,
  output fdiv_ctrl_pkg::fp_flags_t            flags
);

  logic [fdiv_ctrl_pkg::div_iters-1:0] q_norm;
  logic signed [fp_fmt_pkg::exp_w+1:0] exp_n;
  logic signed [fp_fmt_pkg::exp_w+1:0] exp_r;
  logic [fp_fmt_pkg::man_w-1:0]        frac;
  logic [fp_fmt_pkg::man_w:0]          frac_r;
  logic                                guard;
  logic                                round;
  logic                                sticky;
  logic                                inexact;
  logic                                round_up;
  logic                                carry;

  // ========================================
  // Normalize by at most one position
  // ========================================
  always_comb begin
    if (quotient[fdiv_ctrl_pkg::div_iters-1]) begin
      q_norm = quotient;
      exp_n  = exp_diff;
    end else begin
      q_norm = quotient << 1;
      exp_n  = exp_diff - (fp_fmt_pkg::exp_w+2)'(1);
    end
  end

  // Hidden bit sits at the top, then 23 fraction bits, G, R and S
  assign frac    = q_norm[fdiv_ctrl_pkg::div_iters-2:3];
  assign guard   = q_norm[2];
  assign round   = q_norm[1];
  assign sticky  = q_norm[0] | rem_nonzero;
  assign inexact = guard | round | sticky;

  // Decision is applied in this same cycle
  always_comb begin
    case (mode)
      fdiv_ctrl_pkg::rne: round_up = guard & (round | sticky | frac[0]);
      fdiv_ctrl_pkg::rtz: round_up = 1'b0;
      fdiv_ctrl_pkg::rdn: round_up = sign & inexact;
      fdiv_ctrl_pkg::rup: round_up = ~sign & inexact;
      fdiv_ctrl_pkg::rmm: round_up = guard;
      default:            round_up = 1'b0;
    endcase
  end

  // All-ones fraction plus one carries into the exponent
  assign frac_r = {1'b0, frac} + {{fp_fmt_pkg::man_w{1'b0}}, round_up};
  assign carry  = frac_r[fp_fmt_pkg::man_w];
  assign exp_r  = exp_n + $signed({{(fp_fmt_pkg::exp_w+1){1'b0}}, carry});

  // ========================================
  // Range check and packing
  // ========================================
  always_comb begin
    flags = '0;
    if (exp_r >= (fp_fmt_pkg::exp_w+2)'(fp_fmt_pkg::exp_max)) begin
      packed_word = {sign, {fp_fmt_pkg::exp_w{1'b1}}, {fp_fmt_pkg::man_w{1'b0}}};
      flags.of    = 1'b1;
      flags.nx    = 1'b1;
    end else if (exp_n < (fp_fmt_pkg::exp_w+2)'(1)) begin
      // Below normal range, flushed to signed zero
      packed_word = {sign, {fp_fmt_pkg::exp_w{1'b0}}, {fp_fmt_pkg::man_w{1'b0}}};
      flags.uf    = 1'b1;
      flags.nx    = 1'b1;
    end else begin
      packed_word = {sign, exp_r[fp_fmt_pkg::exp_w-1:0], frac_r[fp_fmt_pkg::man_w-1:0]};
      flags.nx    = inexact;
    end
  end

endmodule

`default_nettype wire

/* hw/fdiv_top.sv */
/*
 * Single-precision divider top level: operand capture, control FSM,
 * result and flag registers, classify, divide and round stages
 */
`timescale 1ns/1ps
`default_nettype none

module fdiv_top (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       start,
  input  fdiv_ctrl_pkg::round_mode_e rounding_mode,
  input  fp_fmt_pkg::fp_word_t       operand_a,
  input  fp_fmt_pkg::fp_word_t       operand_b,
  output logic                       busy,
  output logic                       done,
  output fp_fmt_pkg::fp_word_t       result,
  output fdiv_ctrl_pkg::fp_flags_t   flags
);

  fdiv_ctrl_pkg::fdiv_state_e          state_q;
  fdiv_ctrl_pkg::fdiv_state_e          state_d;
  fp_fmt_pkg::fp_word_t                a_q;
  fp_fmt_pkg::fp_word_t                b_q;
  fdiv_ctrl_pkg::round_mode_e          mode_q;

  fp_fmt_pkg::fp_unpacked_t            ua;
  fp_fmt_pkg::fp_unpacked_t            ub;
  logic                                special_hit;
  fp_fmt_pkg::fp_word_t                special_result;
  fdiv_ctrl_pkg::fp_flags_t            special_flags;

  logic                                load;
  logic [fdiv_ctrl_pkg::div_iters-1:0] quotient;
  logic                                rem_nonzero;
  logic                                q_valid;

  logic                                res_sign;
  logic signed [fp_fmt_pkg::exp_w+1:0] exp_diff;
  fp_fmt_pkg::fp_word_t                rp_word;
  fdiv_ctrl_pkg::fp_flags_t            rp_flags;
  logic                                accept;

  assign accept = (state_q == fdiv_ctrl_pkg::idle) && start;

  // Operands stay put for the whole operation
  always_ff @(posedge clk) begin
    if (accept) begin
      a_q    <= operand_a;
      b_q    <= operand_b;
      mode_q <= rounding_mode;
    end
  end

  // ========================================
  // Control FSM
  // ========================================
  always_comb begin
    state_d = state_q;
    load    = 1'b0;
    case (state_q)
      fdiv_ctrl_pkg::idle: begin
        if (start) begin
          state_d = fdiv_ctrl_pkg::unpack;
        end
      end
      fdiv_ctrl_pkg::unpack: begin
        if (special_hit) begin
          state_d = fdiv_ctrl_pkg::done;
        end else begin
          state_d = fdiv_ctrl_pkg::divide;
          load    = 1'b1;
        end
      end
      fdiv_ctrl_pkg::divide: begin
        if (q_valid) begin
          state_d = fdiv_ctrl_pkg::finish;
        end
      end
      fdiv_ctrl_pkg::finish: state_d = fdiv_ctrl_pkg::done;
      fdiv_ctrl_pkg::done:   state_d = fdiv_ctrl_pkg::idle;
      default:               state_d = fdiv_ctrl_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= fdiv_ctrl_pkg::idle;
      result  <= '0;
      flags   <= '0;
    end else begin
      state_q <= state_d;
      if ((state_q == fdiv_ctrl_pkg::unpack) && special_hit) begin
        result <= special_result;
        flags  <= special_flags;
      end else if (state_q == fdiv_ctrl_pkg::finish) begin
        result <= rp_word;
        flags  <= rp_flags;
      end
    end
  end

  assign busy = (state_q != fdiv_ctrl_pkg::idle) && (state_q != fdiv_ctrl_pkg::done);
  assign done = (state_q == fdiv_ctrl_pkg::done);

  // Sign and biased exponent, two extra bits for under and overrange
  assign res_sign = ua.sign ^ ub.sign;
  assign exp_diff = $signed({2'b00, ua.exp}) - $signed({2'b00, ub.exp})
                  + (fp_fmt_pkg::exp_w+2)'(fp_fmt_pkg::bias);

  // ========================================
  // Datapath stages
  // ========================================
  fdiv_classify u_classify (
    .a              (a_q),
    .b              (b_q),
    .ua             (ua),
    .ub             (ub),
    .special_hit    (special_hit),
    .special_result (special_result),
    .special_flags  (special_flags)
  );

  fdiv_mant_divider u_mant_div (
    .clk          (clk),
    .reset_n      (reset_n),
    .load         (load),
    .dividend_sig (ua.sig),
    .divisor_sig  (ub.sig),
    .quotient     (quotient),
    .rem_nonzero  (rem_nonzero),
    .q_valid      (q_valid)
  );

  fdiv_round_pack u_round_pack (
    .quotient    (quotient),
    .rem_nonzero (rem_nonzero),
    .sign        (res_sign),
    .exp_diff    (exp_diff),
    .mode        (mode_q),
    .packed_word (rp_word),
    .flags       (rp_flags)
  );

endmodule

`default_nettype wire

/* hw/fp_fmt_pkg.sv */
/*
 * Single-precision format constants, packed word layout and
 * unpacked operand record
 */
`default_nettype none

package fp_fmt_pkg;

  // ========================================
  // Field layout
  // ========================================
  localparam int exp_w   = 8;
  localparam int man_w   = 23;
  localparam int bias    = 127;
  localparam int exp_max = 255;

  // Quiet NaN, positive sign, top fraction bit set
  localparam logic [31:0] canon_nan = 32'h7FC0_0000;

  // One encoded value
  typedef struct packed {
    logic             sign;
    logic [exp_w-1:0] exp;
    logic [man_w-1:0] frac;
  } fp_word_t;

  // ========================================
  // Operand after unpacking
  // ========================================
  typedef struct packed {
    logic             sign;
    logic [exp_w-1:0] exp;
    logic [man_w:0]   sig;      // Hidden bit on top
    logic             is_nan;
    logic             is_inf;
    logic             is_zero;  // Zero exponent, subnormals included
  } fp_unpacked_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the divider testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_fdiv -f fdiv_top.f -o tb_fdiv > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_fdiv > sim.log 2>&1 || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* tb/fdiv_tests.txt */
# mode operand_a operand_b expected_result expected_flags, all hex
# mode 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm; flag bits nv dz of uf nx
# Exact quotients 6/3, 1/4 and -9/3
0 40C00000 40400000 40000000 00
1 40C00000 40400000 40000000 00
2 40C00000 40400000 40000000 00
3 40C00000 40400000 40000000 00
4 40C00000 40400000 40000000 00
0 3F800000 40800000 3E800000 00
1 3F800000 40800000 3E800000 00
2 3F800000 40800000 3E800000 00
3 3F800000 40800000 3E800000 00
4 3F800000 40800000 3E800000 00
0 C1100000 40400000 C0400000 00
1 C1100000 40400000 C0400000 00
2 C1100000 40400000 C0400000 00
3 C1100000 40400000 C0400000 00
4 C1100000 40400000 C0400000 00
# Inexact 1/3 and -2/3
0 3F800000 40400000 3EAAAAAB 01
1 3F800000 40400000 3EAAAAAA 01
2 3F800000 40400000 3EAAAAAA 01
3 3F800000 40400000 3EAAAAAB 01
4 3F800000 40400000 3EAAAAAB 01
0 C0000000 40400000 BF2AAAAB 01
1 C0000000 40400000 BF2AAAAA 01
2 C0000000 40400000 BF2AAAAB 01
3 C0000000 40400000 BF2AAAAA 01
4 C0000000 40400000 BF2AAAAB 01
# Special cases
0 7F800001 3F800000 7FC00000 10
0 3F800000 FFC00000 7FC00000 10
0 7F800000 FF800000 7FC00000 10
0 00000000 80000000 7FC00000 10
0 FF800000 40000000 FF800000 00
0 40000000 FF800000 80000000 00
0 80000000 C0000000 00000000 00
0 3F800000 80000000 FF800000 08
# Range limits and flushed subnormals
0 FF000000 00800000 FF800000 05
1 7F000000 3F000000 7F800000 05
0 00800000 40000000 00000000 03
0 80800000 7F000000 80000000 03
0 00400000 3F800000 00000000 00
0 3F800000 00000001 7F800000 08

/* tb/tb_fdiv.sv */
/*
 * Testbench for the single-precision divider: vector file reading,
 * stimulus with a second start while busy, result and flag checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fdiv;

  logic                       clk;
  logic                       reset_n;
  logic                       start;
  fdiv_ctrl_pkg::round_mode_e rounding_mode;
  fp_fmt_pkg::fp_word_t       operand_a;
  fp_fmt_pkg::fp_word_t       operand_b;
  logic                       busy;
  logic                       done;
  fp_fmt_pkg::fp_word_t       result;
  fdiv_ctrl_pkg::fp_flags_t   flags;

  // One entry per vector line
  logic [2:0]  vec_mode[$];
  logic [31:0] vec_a[$];
  logic [31:0] vec_b[$];
  logic [31:0] vec_res[$];
  logic [4:0]  vec_flags[$];

  int pass_count;
  int fail_count;
  bit timed_out;

  fdiv_top u_dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .rounding_mode (rounding_mode),
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .busy          (busy),
    .done          (done),
    .result        (result),
    .flags         (flags)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ========================================
  // Vector file
  // ========================================
  task automatic load_vectors(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_mode;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_res;
    logic [31:0] f_flags;
    ok = 1'b0;
    fd = $fopen("tb/fdiv_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file tb/fdiv_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Comment lines are skipped and blank lines fail the scan
      if ((n > 0) && (line.getc(0) != "#")) begin
        n = $sscanf(line, "%h %h %h %h %h", f_mode, f_a, f_b, f_res, f_flags);
        if (n == 5) begin
          vec_mode.push_back(f_mode[2:0]);
          vec_a.push_back(f_a);
          vec_b.push_back(f_b);
          vec_res.push_back(f_res);
          vec_flags.push_back(f_flags[4:0]);
        end
      end
    end
    $fclose(fd);
    ok = (vec_a.size() > 0);
  endtask

  // ========================================
  // One division per vector with a second start on odd vectors
  // ========================================
  task automatic run_vector(input int idx);
    int                       cycles;
    bit                       got_done;
    bit                       vec_ok;
    fp_fmt_pkg::fp_word_t     exp_res;
    fdiv_ctrl_pkg::fp_flags_t exp_flags;
    exp_res   = vec_res[idx];
    exp_flags = fdiv_ctrl_pkg::fp_flags_t'(vec_flags[idx]);
    vec_ok    = 1'b1;
    @(negedge clk);
    start         = 1'b1;
    rounding_mode = fdiv_ctrl_pkg::round_mode_e'(vec_mode[idx]);
    operand_a     = vec_a[idx];
    operand_b     = vec_b[idx];
    @(negedge clk);
    start = 1'b0;
    assert (busy) else begin
      $display("vector %0d: busy not raised after the start was accepted", idx);
      vec_ok = 1'b0;
    end
    if (idx % 2 == 1) begin
      start         = 1'b1;
      rounding_mode = fdiv_ctrl_pkg::round_mode_e'(3'($urandom_range(0, 4)));
      operand_a     = $urandom();
      operand_b     = $urandom();
    end
    cycles   = 0;
    got_done = 1'b0;
    while (!got_done && (cycles < 100)) begin
      @(negedge clk);
      start    = 1'b0;
      got_done = done;
      cycles++;
    end
    if (!got_done) begin
      $display("vector %0d: no done pulse within 100 cycles", idx);
      fail_count++;
      timed_out = 1'b1;
      return;
    end
    assert (result == exp_res) else begin
      $display("FAILED at %0t: vector %0d result %h, expected %h", $time, idx, result, exp_res);
      vec_ok = 1'b0;
    end
    assert (flags == exp_flags) else begin
      $display("FAILED at %0t: vector %0d flags %b, expected %b", $time, idx, flags, exp_flags);
      vec_ok = 1'b0;
    end
    assert (!busy) else begin
      $display("vector %0d: busy still high while done is asserted", idx);
      vec_ok = 1'b0;
    end
    @(negedge clk);
    assert (!done && (result == exp_res)) else begin
      $display("vector %0d: done longer than one cycle or result not held", idx);
      vec_ok = 1'b0;
    end
    $display("vector %0d mode %0d: %h / %h = %h flags %b  %s", idx, vec_mode[idx],
             vec_a[idx], vec_b[idx], result, flags, vec_ok ? "ok" : "wrong");
    if (vec_ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    bit loaded;
    int idx;
    reset_n       = 1'b0;
    start         = 1'b0;
    rounding_mode = fdiv_ctrl_pkg::rne;
    operand_a     = '0;
    operand_b     = '0;
    pass_count    = 0;
    fail_count    = 0;
    timed_out     = 1'b0;
    void'($urandom(37019));
    load_vectors(loaded);
    if (!loaded) begin
      fail_count++;
    end
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    assert (!busy && !done && (result == '0) && (flags == '0)) else begin
      $display("outputs not cleared by reset");
      fail_count++;
    end
    idx = 0;
    while (loaded && !timed_out && (idx < vec_a.size())) begin
      run_vector(idx);
      repeat ($urandom_range(0, 5)) @(negedge clk);
      idx++;
    end
    $display("%0d vectors passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
